/* files.f */
hw/lsu_pkg.sv
hw/load_issue_stage.sv
hw/load_lane.sv
hw/load_data_ram.sv
hw/load_wb_collect.sv
hw/lsu_top.sv
verification/lsu_tb.sv

/* verification/lsu_tb.sv */
module lsu_tb
    import lsu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES        = 2;
    localparam int WORDS        = 64;
    localparam int PERIOD       = 100;
    localparam int N_WRITES     = 2 * WORDS;
    localparam int N_LOADS      = 300;
    localparam int N_REDIRECTS  = 300;
    localparam int TOTAL_OPS    = N_WRITES + N_LOADS + N_REDIRECTS;
    localparam int LIMIT_CYCLES = TOTAL_OPS * 4 + 200;

    // one expected writeback, due at the edge where the collector registers it
    typedef struct {
        int        due;
        bit        alive;
        rob_idx_t  rob;
        preg_t     rd;
        word_t     res;
        exc_code_e exc;
        vaddr_t    vaddr;
    } exp_wb_t;

    logic       clk = 1'b0;
    logic       rst;
    load_req_t  req [LANES];
    logic       redirect;
    rob_idx_t   redirect_rob;
    logic       mem_we;
    word_addr_t mem_waddr;
    byte_mask_t mem_wmask;
    word_t      mem_wdata;
    load_wb_t   wb [LANES];
    logic       exc_valid;
    rob_idx_t   exc_rob;
    vaddr_t     exc_vaddr;

    integer     seed = 32'h88cd_0736;
    string      test_name = "reset";
    int         cyc;
    int         n_wb;
    logic [5:0] rob_ctr;

    word_t      model_mem [WORDS];
    exp_wb_t    exp_q [LANES][$];
    exp_wb_t    exp_cur [LANES];
    bit         exp_en [LANES];
    bit         m_exc_valid;
    rob_idx_t   m_exc_rob;
    vaddr_t     m_exc_vaddr;

    lsu_top #(
        .LOAD_LANES(LANES),
        .RAM_WORDS (WORDS)
    ) i_lsu_top (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .redirect_i    (redirect),
        .redirect_rob_i(redirect_rob),
        .mem_we_i      (mem_we),
        .mem_waddr_i   (mem_waddr),
        .mem_wmask_i   (mem_wmask),
        .mem_wdata_i   (mem_wdata),
        .wb_o          (wb),
        .exc_valid_o   (exc_valid),
        .exc_rob_o     (exc_rob),
        .exc_vaddr_o   (exc_vaddr)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic fail_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error [%s] %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            fail_run();
        end
    endtask

    // a is older than b when b lies less than half the rob space ahead of a
    function automatic bit is_older(rob_idx_t a, rob_idx_t b);
        logic [5:0] av;
        logic [5:0] bv;
        logic [5:0] ahead;
        av    = a;
        bv    = b;
        ahead = bv - av;
        return ahead != 6'd0 && ahead < 6'd32;
    endfunction

    function automatic exp_wb_t predict_load(load_req_t rq);
        exp_wb_t e;
        vaddr_t  va;
        word_t   nbytes;
        word_t   shifted;
        va      = rq.base + rq.imm;
        nbytes  = 32'd1 << rq.size;
        shifted = model_mem[(va >> 2) % WORDS] >> (8 * va[1:0]);
        e.due   = cyc + 3;
        e.alive = 1'b1;
        e.rob   = rq.rob;
        e.rd    = rq.rd;
        e.vaddr = va;
        if ((va % nbytes) != 0) begin
            e.res = '0;
            e.exc = LOAD_MISALIGN;
        end else begin
            e.exc = NONE;
            case (rq.size)
                BYTE:    e.res = rq.uext ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
                HALF:    e.res = rq.uext ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
                default: e.res = shifted;
            endcase
        end
        return e;
    endfunction

    // runs at every edge the DUT sees out of reset, with the inputs it samples
    task automatic model_edge();
        bit       cand_valid;
        rob_idx_t cand_rob;
        vaddr_t   cand_vaddr;
        cyc++;
        for (int l = 0; l < LANES; l++) begin
            if (req[l].valid) begin
                exp_q[l].push_back(predict_load(req[l]));
            end
        end
        if (redirect) begin
            for (int l = 0; l < LANES; l++) begin
                for (int i = 0; i < exp_q[l].size(); i++) begin
                    if (exp_q[l][i].due >= cyc && is_older(redirect_rob, exp_q[l][i].rob)) begin
                        exp_q[l][i].alive = 1'b0;
                    end
                end
            end
        end
        cand_valid = 1'b0;
        cand_rob   = '0;
        cand_vaddr = '0;
        for (int l = 0; l < LANES; l++) begin
            exp_en[l] = 1'b0;
            if (exp_q[l].size() > 0 && exp_q[l][0].due == cyc) begin
                exp_cur[l] = exp_q[l].pop_front();
                exp_en[l]  = exp_cur[l].alive;
                if (exp_en[l] && exp_cur[l].exc != NONE &&
                    (!cand_valid || is_older(exp_cur[l].rob, cand_rob))) begin
                    cand_valid = 1'b1;
                    cand_rob   = exp_cur[l].rob;
                    cand_vaddr = exp_cur[l].vaddr;
                end
            end
        end
        if (m_exc_valid && redirect && is_older(redirect_rob, m_exc_rob)) begin
            m_exc_valid = 1'b0;
        end else if (cand_valid && (!m_exc_valid || is_older(cand_rob, m_exc_rob))) begin
            m_exc_valid = 1'b1;
            m_exc_rob   = cand_rob;
            m_exc_vaddr = cand_vaddr;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            model_edge();
        end
    end

    // outputs settle after the edge, compare half a cycle later
    always @(negedge clk) begin
        if (cyc > 0) begin
            for (int l = 0; l < LANES; l++) begin
                check_value($sformatf("lane %0d wb en", l), exp_en[l], wb[l].en);
                if (exp_en[l]) begin
                    n_wb++;
                    check_value($sformatf("lane %0d rob", l), exp_cur[l].rob, wb[l].rob);
                    check_value($sformatf("lane %0d rd", l), exp_cur[l].rd, wb[l].rd);
                    check_value($sformatf("lane %0d res", l), exp_cur[l].res, wb[l].res);
                    check_value($sformatf("lane %0d exccode", l), exp_cur[l].exc, wb[l].exccode);
                end
            end
            check_value("exc valid", m_exc_valid, exc_valid);
            if (m_exc_valid) begin
                check_value("exc rob", m_exc_rob, exc_rob);
                check_value("exc vaddr", m_exc_vaddr, exc_vaddr);
            end
        end
    end

    function automatic load_req_t random_load(logic [5:0] rob);
        load_req_t rq;
        vaddr_t    va;
        word_t     amask;
        rq.valid = ($unsigned($random(seed)) % 4) != 0;
        rq.rob   = rob;
        rq.rd    = preg_t'($random(seed));
        rq.base  = $random(seed);
        rq.imm   = $random(seed);
        rq.size  = mem_size_e'(2'($unsigned($random(seed)) % 3));
        rq.uext  = 1'($random(seed));
        // most loads get pulled onto their natural boundary
        amask = (32'd1 << rq.size) - 32'd1;
        if (($unsigned($random(seed)) % 4) != 0) begin
            va     = rq.base + rq.imm;
            rq.imm = rq.imm - (va & amask);
        end
        return rq;
    endfunction

    task automatic write_memory();
        word_addr_t a;
        byte_mask_t m;
        word_t      d;
        int         row;
        for (int i = 0; i < N_WRITES; i++) begin
            // first pass fills every word
            if (i < WORDS) begin
                a = word_addr_t'(i);
                m = 4'hf;
            end else begin
                a = word_addr_t'($random(seed));
                m = byte_mask_t'($random(seed));
                if (m == 4'h0) begin
                    m = 4'hf;
                end
            end
            d   = $random(seed);
            row = int'(a % WORDS);
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    model_mem[row][b*8 +: 8] = d[b*8 +: 8];
                end
            end
            @(posedge clk);
            mem_we    <= 1'b1;
            mem_waddr <= a;
            mem_wmask <= m;
            mem_wdata <= d;
        end
        @(posedge clk);
        mem_we <= 1'b0;
    endtask

    task automatic issue_loads(int cycles, bit with_redirects);
        load_req_t  rq;
        bit         redir;
        logic [5:0] back;
        logic [5:0] target;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            redir  = with_redirects && (($unsigned($random(seed)) % 16) == 0);
            back   = 6'(1 + $unsigned($random(seed)) % 8);
            target = rob_ctr - back;
            redirect     <= redir;
            redirect_rob <= target;
            for (int l = 0; l < LANES; l++) begin
                rq = random_load(rob_ctr);
                if (rq.valid) begin
                    rob_ctr = rob_ctr + 6'd1;
                end
                req[l] <= rq;
            end
            // issue resumes right after the branch
            if (redir) begin
                rob_ctr = target + 6'd1;
            end
        end
        @(posedge clk);
        redirect <= 1'b0;
        for (int l = 0; l < LANES; l++) begin
            req[l].valid <= 1'b0;
        end
    endtask

    initial begin
        int leftover;
        rst          = 1'b1;
        redirect     = 1'b0;
        redirect_rob = '0;
        mem_we       = 1'b0;
        mem_waddr    = '0;
        mem_wmask    = '0;
        mem_wdata    = '0;
        for (int l = 0; l < LANES; l++) begin
            req[l] = '0;
        end
        m_exc_valid = 1'b0;
        m_exc_rob   = '0;
        m_exc_vaddr = '0;
        rob_ctr     = '0;
        cyc         = 0;
        n_wb        = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_name = "memory writes";
        write_memory();
        test_name = "loads";
        issue_loads(N_LOADS, 1'b0);
        test_name = "loads with redirects";
        issue_loads(N_REDIRECTS, 1'b1);
        repeat (6) @(posedge clk);
        leftover = 0;
        for (int l = 0; l < LANES; l++) begin
            leftover += exp_q[l].size();
        end
        if (leftover != 0) begin
            $display("%0d expected writebacks never came out of the DUT", leftover);
            fail_run();
        end else begin
            $display("%0d writebacks checked", n_wb);
            $display("Test passed");
            $finish;
        end
    end

    initial begin
        #(LIMIT_CYCLES * PERIOD);
        $display("watchdog: run timed out after %0d cycles", LIMIT_CYCLES);
        fail_run();
    end

endmodule

/* hw/lsu_top.sv */
module lsu_top
    import lsu_pkg::*;
#(
    parameter int LOAD_LANES = 2,
    parameter int RAM_WORDS  = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  load_req_t  req_i [LOAD_LANES],
    input  logic       redirect_i,
    input  rob_idx_t   redirect_rob_i,
    input  logic       mem_we_i,
    input  word_addr_t mem_waddr_i,
    input  byte_mask_t mem_wmask_i,
    input  word_t      mem_wdata_i,
    output load_wb_t   wb_o [LOAD_LANES],
    output logic       exc_valid_o,
    output rob_idx_t   exc_rob_o,
    output vaddr_t     exc_vaddr_o
);

    load_req_t  issue      [LOAD_LANES];
    word_addr_t rd_addr    [LOAD_LANES];
    word_t      rd_data    [LOAD_LANES];
    load_wb_t   lane_wb    [LOAD_LANES];
    vaddr_t     lane_vaddr [LOAD_LANES];

    load_issue_stage #(
        .LOAD_LANES(LOAD_LANES)
    ) i_issue (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .redirect_i    (redirect_i),
        .redirect_rob_i(redirect_rob_i),
        .issue_o       (issue)
    );

    generate
        for (genvar l = 0; l < LOAD_LANES; l++) begin : g_lane
            load_lane i_lane (
                .clk           (clk),
                .rst           (rst),
                .issue_i       (issue[l]),
                .redirect_i    (redirect_i),
                .redirect_rob_i(redirect_rob_i),
                .rd_addr_o     (rd_addr[l]),
                .rd_data_i     (rd_data[l]),
                .wb_o          (lane_wb[l]),
                .vaddr_o       (lane_vaddr[l])
            );
        end
    endgenerate

    load_data_ram #(
        .LOAD_LANES(LOAD_LANES),
        .RAM_WORDS (RAM_WORDS)
    ) i_ram (
        .clk      (clk),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data),
        .we_i     (mem_we_i),
        .waddr_i  (mem_waddr_i),
        .wmask_i  (mem_wmask_i),
        .wdata_i  (mem_wdata_i)
    );

    load_wb_collect #(
        .LOAD_LANES(LOAD_LANES)
    ) i_collect (
        .clk           (clk),
        .rst           (rst),
        .lane_wb_i     (lane_wb),
        .lane_vaddr_i  (lane_vaddr),
        .redirect_i    (redirect_i),
        .redirect_rob_i(redirect_rob_i),
        .wb_o          (wb_o),
        .exc_valid_o   (exc_valid_o),
        .exc_rob_o     (exc_rob_o),
        .exc_vaddr_o   (exc_vaddr_o)
    );

endmodule

/* hw/load_wb_collect.sv */
module load_wb_collect
    import lsu_pkg::*;
#(
    parameter int LOAD_LANES = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  load_wb_t lane_wb_i [LOAD_LANES],
    input  vaddr_t   lane_vaddr_i [LOAD_LANES],
    input  logic     redirect_i,
    input  rob_idx_t redirect_rob_i,
    output load_wb_t wb_o [LOAD_LANES],
    output logic     exc_valid_o,
    output rob_idx_t exc_rob_o,
    output vaddr_t   exc_vaddr_o
);

    logic [LOAD_LANES-1:0] lane_live;
    load_wb_t              wb_q [LOAD_LANES];

    logic     cand_valid;
    rob_idx_t cand_rob;
    vaddr_t   cand_vaddr;

    logic     exc_valid_q;
    rob_idx_t exc_rob_q;
    vaddr_t   exc_vaddr_q;
    logic     redirect_clears;
    logic     cand_wins;

    generate
        for (genvar l = 0; l < LOAD_LANES; l++) begin : g_lane
            assign lane_live[l] = lane_wb_i[l].en &&
                !(redirect_i && rob_older(redirect_rob_i, lane_wb_i[l].rob));

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    wb_q[l].en <= 1'b0;
                end else begin
                    wb_q[l]    <= lane_wb_i[l];
                    wb_q[l].en <= lane_live[l];
                end
            end

            assign wb_o[l] = wb_q[l];
        end
    endgenerate

    // oldest surviving exception this cycle
    always_comb begin
        cand_valid = 1'b0;
        cand_rob   = lane_wb_i[0].rob;
        cand_vaddr = lane_vaddr_i[0];
        for (int l = 0; l < LOAD_LANES; l++) begin
            if (lane_live[l] && lane_wb_i[l].exccode != NONE &&
                (!cand_valid || rob_older(lane_wb_i[l].rob, cand_rob))) begin
                cand_valid = 1'b1;
                cand_rob   = lane_wb_i[l].rob;
                cand_vaddr = lane_vaddr_i[l];
            end
        end
    end

    assign redirect_clears = exc_valid_q && redirect_i &&
                             rob_older(redirect_rob_i, exc_rob_q);
    assign cand_wins       = cand_valid && (!exc_valid_q || rob_older(cand_rob, exc_rob_q));

    // flush of the excepting load wins over a new one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exc_valid_q <= 1'b0;
        end else if (redirect_clears) begin
            exc_valid_q <= 1'b0;
        end else if (cand_wins) begin
            exc_valid_q <= 1'b1;
            exc_rob_q   <= cand_rob;
            exc_vaddr_q <= cand_vaddr;
        end
    end

    assign exc_valid_o = exc_valid_q;
    assign exc_rob_o   = exc_rob_q;
    assign exc_vaddr_o = exc_vaddr_q;

endmodule

/* hw/load_data_ram.sv */
module load_data_ram
    import lsu_pkg::*;
#(
    parameter int LOAD_LANES = 2,
    parameter int RAM_WORDS  = 64
) (
    input  logic       clk,
    input  word_addr_t rd_addr_i [LOAD_LANES],
    output word_t      rd_data_o [LOAD_LANES],
    input  logic       we_i,
    input  word_addr_t waddr_i,
    input  byte_mask_t wmask_i,
    input  word_t      wdata_i
);

    localparam int AW = $clog2(RAM_WORDS);

    word_t         mem [RAM_WORDS];
    logic [AW-1:0] wr_row;

    assign wr_row = AW'(waddr_i % RAM_WORDS);

    // committed stores, byte granular
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < BYTE_LANES; b++) begin
                if (wmask_i[b]) begin
                    mem[wr_row][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    generate
        for (genvar l = 0; l < LOAD_LANES; l++) begin : g_rd
            logic [AW-1:0] rd_row;

            assign rd_row = AW'(rd_addr_i[l] % RAM_WORDS);

            // same cycle write is not visible
            always_ff @(posedge clk) begin
                rd_data_o[l] <= mem[rd_row];
            end
        end
    endgenerate

    a_wmask_nonzero: assert property (
        @(posedge clk) we_i |-> wmask_i != '0
    ) else $error("memory write with empty byte mask");

endmodule

/* hw/load_lane.sv */
module load_lane
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  load_req_t  issue_i,
    input  logic       redirect_i,
    input  rob_idx_t   redirect_rob_i,
    output word_addr_t rd_addr_o,
    input  word_t      rd_data_i,
    output load_wb_t   wb_o,
    output vaddr_t     vaddr_o
);

    // what stage 2 needs from stage 1
    typedef struct packed {
        rob_idx_t   rob;
        preg_t      rd;
        vaddr_t     vaddr;
        byte_mask_t mask;
        mem_size_e  size;
        logic       uext;
        logic       misalign;
    } s2_t;

    vaddr_t     vaddr;
    logic       misalign;
    logic [7:0] mask_wide;
    logic       kill_s1;

    logic       s2_valid;
    s2_t        s2_q;
    logic       kill_s2;
    word_t      masked;
    word_t      picked;
    word_t      extended;

    load_wb_t   wb_q;
    vaddr_t     vaddr_q;

    // stage 1, address and checks
    assign vaddr = issue_i.base + issue_i.imm;

    always_comb begin
        case (issue_i.size)
            WORD:    misalign = |vaddr[1:0];
            HALF:    misalign = vaddr[0];
            default: misalign = 1'b0;
        endcase
    end

    // spills into the upper nibble only when the access crosses a word
    always_comb begin
        case (issue_i.size)
            WORD:    mask_wide = 8'h0f << vaddr[1:0];
            HALF:    mask_wide = 8'h03 << vaddr[1:0];
            default: mask_wide = 8'h01 << vaddr[1:0];
        endcase
    end

    assign rd_addr_o = vaddr[XLEN-1:2];
    assign kill_s1   = redirect_i && rob_older(redirect_rob_i, issue_i.rob);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid      <= issue_i.valid && !kill_s1;
            s2_q.rob      <= issue_i.rob;
            s2_q.rd       <= issue_i.rd;
            s2_q.vaddr    <= vaddr;
            s2_q.mask     <= mask_wide[3:0];
            s2_q.size     <= issue_i.size;
            s2_q.uext     <= issue_i.uext;
            s2_q.misalign <= misalign;
        end
    end

    // stage 2, data alignment
    assign kill_s2 = redirect_i && rob_older(redirect_rob_i, s2_q.rob);

    always_comb begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            masked[b*8 +: 8] = s2_q.mask[b] ? rd_data_i[b*8 +: 8] : 8'h00;
        end
    end

    assign picked = masked >> {s2_q.vaddr[1:0], 3'b000};

    always_comb begin
        case (s2_q.size)
            BYTE:    extended = {{(XLEN-8){~s2_q.uext & picked[7]}}, picked[7:0]};
            HALF:    extended = {{(XLEN-16){~s2_q.uext & picked[15]}}, picked[15:0]};
            WORD:    extended = picked;
            default: extended = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_q.en <= 1'b0;
        end else begin
            wb_q.en      <= s2_valid && !kill_s2;
            wb_q.rob     <= s2_q.rob;
            wb_q.rd      <= s2_q.rd;
            // misaligned loads carry no data
            wb_q.res     <= s2_q.misalign ? '0 : extended;
            wb_q.exccode <= s2_q.misalign ? LOAD_MISALIGN : NONE;
            vaddr_q      <= s2_q.vaddr;
        end
    end

    assign wb_o    = wb_q;
    assign vaddr_o = vaddr_q;

    a_mask_in_word: assert property (
        @(posedge clk) disable iff (rst)
        issue_i.valid && !misalign |-> mask_wide[7:4] == 4'h0
    ) else $error("aligned load mask crosses a word");

endmodule

/* hw/load_issue_stage.sv */
module load_issue_stage
    import lsu_pkg::*;
#(
    parameter int LOAD_LANES = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  load_req_t req_i [LOAD_LANES],
    input  logic      redirect_i,
    input  rob_idx_t  redirect_rob_i,
    output load_req_t issue_o [LOAD_LANES]
);

    load_req_t issue_q [LOAD_LANES];
    logic [LOAD_LANES-1:0] kill;

    generate
        for (genvar l = 0; l < LOAD_LANES; l++) begin : g_lane
            // incoming load younger than the redirect never enters the pipe
            assign kill[l] = redirect_i && rob_older(redirect_rob_i, req_i[l].rob);

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    issue_q[l].valid <= 1'b0;
                end else begin
                    issue_q[l]       <= req_i[l];
                    issue_q[l].valid <= req_i[l].valid && !kill[l];
                end
            end

            assign issue_o[l] = issue_q[l];

            a_legal_size: assert property (
                @(posedge clk) disable iff (rst)
                req_i[l].valid |-> req_i[l].size != mem_size_e'(2'b11)
            ) else $error("illegal load size on lane %0d", l);
        end
    endgenerate

endmodule

/* hw/lsu_pkg.sv */
package lsu_pkg;

    localparam int XLEN       = 32;
    localparam int ROB_WIDTH  = 5;
    localparam int PREG_WIDTH = 6;
    localparam int BYTE_LANES = XLEN / 8;
    localparam int EXC_WIDTH  = 4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       vaddr_t;
    typedef logic [BYTE_LANES-1:0] byte_mask_t;
    typedef logic [PREG_WIDTH-1:0] preg_t;
    // word index into the data memory, vaddr without the byte offset
    typedef logic [XLEN-3:0]       word_addr_t;

    // dir flips each time the reorder buffer wraps
    typedef struct packed {
        logic                 dir;
        logic [ROB_WIDTH-1:0] idx;
    } rob_idx_t;

    // 2'b11 is illegal
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    typedef enum logic [EXC_WIDTH-1:0] {
        NONE          = 4'd0,
        LOAD_MISALIGN = 4'd4
    } exc_code_e;

    // issue inputs of one lane
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob;
        preg_t     rd;
        word_t     base;
        word_t     imm;
        mem_size_e size;
        logic      uext;
    } load_req_t;

    typedef struct packed {
        logic      en;
        rob_idx_t  rob;
        preg_t     rd;
        word_t     res;
        exc_code_e exccode;
    } load_wb_t;

    // true when a is older than b
    function automatic logic rob_older(input rob_idx_t a, input rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx < b.idx;
        end
        // b has wrapped past a
        return a.idx > b.idx;
    endfunction

endpackage
